/* all.f */
hdl/wake_pkg.sv
hdl/intr_collector.sv
hdl/event_fifo.sv
hdl/wake_controller.sv
hdl/wake_unit.sv
testbench/wake_unit_assert.sv
testbench/wake_unit_tb.sv

/* Makefile */
TOP := wake_unit_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" sim.log || (echo "simulation ended early"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* testbench/wake_unit_tb.sv */
`timescale 1ns/1ps
// testbench for the wake unit
// table-driven interrupt pulses, power-switch acknowledge model, event and power checks

module wake_unit_tb;

  localparam int NUM_INTR   = 16;
  localparam int FIFO_DEPTH = 4;
  localparam int NUM_ROWS   = 8;
  localparam int WAIT_LIMIT = 200;
  localparam wake_pkg::pwr_ctrl_t DOM_UP   = 3'b011;
  localparam wake_pkg::pwr_ctrl_t DOM_DOWN = 3'b100;

  logic                      clk_i = 1'b0;
  logic                      rst_i;
  logic [NUM_INTR-1:0]       intr_i;
  logic                      core_sleep_i;
  logic                      switch_ack_ni;
  logic                      event_ready_i;
  logic                      event_valid_o;
  logic [wake_pkg::ID_W-1:0] event_id_o;
  logic                      event_overrun_o;
  logic                      powergate_switch_no;
  logic                      powergate_iso_no;
  logic                      subsystem_rst_no;

  // expected ids one nibble per event, first event leftmost, same for overrun bits
  logic [NUM_INTR-1:0] row_mask [NUM_ROWS];
  int                  row_pulses [NUM_ROWS];
  bit                  row_hold [NUM_ROWS];
  bit                  row_sleep [NUM_ROWS];
  int                  row_count [NUM_ROWS];
  logic [63:0]         row_ids [NUM_ROWS];
  logic [15:0]         row_ovr [NUM_ROWS];

  wake_pkg::event_t got [$];
  integer           seed = 32'hd370_d245;
  int               ack_delay;
  int               mismatches = 0;
  int               failures = 0;

  wake_unit #(
    .NUM_INTR  (NUM_INTR),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_wake_unit (.*);

  always #5 clk_i = ~clk_i;

  // switch cells report power good a few cycles after the switch moves
  always @(posedge clk_i) begin
    if (switch_ack_ni !== powergate_switch_no) begin
      ack_delay = 1 + int'($unsigned($random(seed)) % 4);
      repeat (ack_delay - 1) @(posedge clk_i);
      #1 switch_ack_ni = powergate_switch_no;
    end
  end

  function automatic wake_pkg::pwr_ctrl_t pwr_now();
    return {powergate_switch_no, powergate_iso_no, subsystem_rst_no};
  endfunction

  // accepted events, and no offer unless the domain is fully up
  always @(negedge clk_i) begin
    if (!rst_i && event_valid_o) begin
      if (pwr_now() !== DOM_UP) begin
        $display("event presented while the cpu domain is not fully powered");
        failures++;
      end
      if (event_ready_i) begin
        got.push_back({event_id_o, event_overrun_o});
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_event(input wake_pkg::event_t seen, input wake_pkg::event_t want,
                             input int idx);
    if (seen.id !== want.id) begin
      $display("mismatch event_id_o (event %0d): got %h, expected %h", idx, seen.id, want.id);
      mismatches++;
    end
    if (seen.overrun !== want.overrun) begin
      $display("mismatch event_overrun_o (event %0d): got %h, expected %h",
               idx, seen.overrun, want.overrun);
      mismatches++;
    end
  endtask

  task automatic check_pwr(input wake_pkg::pwr_ctrl_t want);
    wake_pkg::pwr_ctrl_t cur;
    cur = pwr_now();
    if (cur.pwrgate_en_n !== want.pwrgate_en_n) begin
      $display("mismatch powergate_switch_no: got %h, expected %h",
               cur.pwrgate_en_n, want.pwrgate_en_n);
      mismatches++;
    end
    if (cur.isogate_en_n !== want.isogate_en_n) begin
      $display("mismatch powergate_iso_no: got %h, expected %h",
               cur.isogate_en_n, want.isogate_en_n);
      mismatches++;
    end
    if (cur.rst_n !== want.rst_n) begin
      $display("mismatch subsystem_rst_no: got %h, expected %h", cur.rst_n, want.rst_n);
      mismatches++;
    end
  endtask

  task automatic wait_ack(input logic level);
    int cyc;
    cyc = 0;
    do begin
      @(negedge clk_i);
      cyc++;
    end while (switch_ack_ni !== level && cyc < WAIT_LIMIT);
    if (switch_ack_ni !== level) begin
      $display("timeout waiting for the power switch acknowledge");
      failures++;
    end
  endtask

  task automatic wait_events(input int n);
    int cyc;
    cyc = 0;
    while (got.size() < n && cyc < WAIT_LIMIT) begin
      @(posedge clk_i);
      cyc++;
    end
    if (got.size() < n) begin
      $display("timeout waiting for %0d events, only %0d arrived", n, got.size());
      failures++;
    end
  endtask

  task automatic set_row(input int r, input logic [NUM_INTR-1:0] mask, input int pulses,
                         input bit hold, input bit sleep, input int count,
                         input logic [63:0] ids, input logic [15:0] ovr);
    row_mask[r]   = mask;
    row_pulses[r] = pulses;
    row_hold[r]   = hold;
    row_sleep[r]  = sleep;
    row_count[r]  = count;
    row_ids[r]    = ids;
    row_ovr[r]    = ovr;
  endtask

  task automatic run_row(input int r);
    wake_pkg::event_t want;
    int n;
    int p;
    int j;
    n = row_count[r];
    got.delete();
    next_cycle();
    event_ready_i = !row_hold[r];
    if (row_sleep[r]) begin
      core_sleep_i = 1'b1;
      // switch cells acknowledge once the switch has opened
      wait_ack(1'b1);
      check_pwr(DOM_DOWN);
      next_cycle();
    end
    for (p = 0; p < row_pulses[r]; p++) begin
      intr_i = row_mask[r];
      next_cycle();
      intr_i = '0;
      // the core wakes on its interrupt
      core_sleep_i = 1'b0;
      repeat (8) next_cycle();
    end
    event_ready_i = 1'b1;
    wait_events(n);
    repeat (10) @(negedge clk_i);
    if (got.size() != n) begin
      $display("row %0d: expected %0d events but %0d arrived", r, n, got.size());
      failures++;
    end
    for (j = 0; j < n && j < got.size(); j++) begin
      want.id      = row_ids[r][4*(n-1-j) +: 4];
      want.overrun = row_ovr[r][n-1-j];
      check_event(got[j], want, j);
    end
    check_pwr(DOM_UP);
  endtask

  initial begin
    rst_i         = 1'b1;
    intr_i        = '0;
    core_sleep_i  = 1'b0;
    switch_ack_ni = 1'b0;
    event_ready_i = 1'b1;
    // mask, pulses, hold ready, sleep, count, ids, overrun flags
    set_row(0, 16'h0020, 1, 1'b0, 1'b0, 1, 64'h5, 16'h0);
    set_row(1, 16'h0001, 1, 1'b0, 1'b0, 1, 64'h0, 16'h0);
    set_row(2, 16'h1000, 1, 1'b0, 1'b0, 1, 64'hc, 16'h0);
    set_row(3, 16'h8000, 1, 1'b0, 1'b0, 1, 64'hf, 16'h0);
    set_row(4, 16'h028a, 1, 1'b0, 1'b0, 4, 64'h1379, 16'h0);
    // line 4 stalls behind a full queue, its second edge is an overrun
    set_row(5, 16'h001f, 2, 1'b1, 1'b0, 9, 64'h0_1234_0123, 16'h0010);
    set_row(6, 16'hffff, 1, 1'b1, 1'b0, 16, 64'h0123_4567_89ab_cdef, 16'h0);
    set_row(7, 16'h0040, 1, 1'b0, 1'b1, 1, 64'h6, 16'h0);
    repeat (5) @(posedge clk_i);
    #1 rst_i = 1'b0;
    @(negedge clk_i);
    check_pwr(DOM_UP);
    if (event_valid_o !== 1'b0) begin
      $display("mismatch event_valid_o: got %h, expected 0", event_valid_o);
      mismatches++;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // hard stop if the run stalls
  initial begin
    #2_000_000;
    $display("simulation watchdog expired");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* testbench/wake_unit_assert.sv */
`timescale 1ns/1ps
// wake unit checkers
// cpu domain power sequence order and valid/ready hold rules

module wake_unit_assert (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      ev_valid_i,
  input logic                      ev_ready_i,
  input wake_pkg::event_t          ev_data_i,
  input logic                      event_valid_i,
  input logic                      event_ready_i,
  input logic [wake_pkg::ID_W-1:0] event_id_i,
  input logic                      event_overrun_i,
  input wake_pkg::pwr_ctrl_t       pwr_ctrl_i
);

  // iso already active when reset goes down
  iso_before_rst: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(pwr_ctrl_i.rst_n) |-> $past(!pwr_ctrl_i.isogate_en_n))
    else $error("cpu reset asserted before isolation");

  // switch only opens with reset held
  rst_before_switch: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(pwr_ctrl_i.pwrgate_en_n) |-> !pwr_ctrl_i.rst_n)
    else $error("power switch opened while cpu reset released");

  // stalled collector offer keeps its line
  ev_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    ev_valid_i && !ev_ready_i |=> ev_valid_i && $stable(ev_data_i.id))
    else $error("collector offer changed before transfer");

  out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    event_valid_i && !event_ready_i |=>
      event_valid_i && $stable(event_id_i) && $stable(event_overrun_i))
    else $error("event output changed before transfer");

endmodule

bind wake_unit wake_unit_assert u_wake_unit_assert (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .ev_valid_i     (ev_valid),
  .ev_ready_i     (ev_ready),
  .ev_data_i      (ev_data),
  .event_valid_i  (event_valid_o),
  .event_ready_i  (event_ready_i),
  .event_id_i     (event_id_o),
  .event_overrun_i(event_overrun_o),
  .pwr_ctrl_i     (pwr_ctrl)
);

/* hdl/wake_unit.sv */
`timescale 1ns/1ps
// wake unit top
// fast interrupt collection, event queue and cpu domain power sequencing

module wake_unit #(
  parameter int NUM_INTR   = wake_pkg::MAX_INTR,
  parameter int FIFO_DEPTH = wake_pkg::DEF_FIFO_DEPTH
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [NUM_INTR-1:0]       intr_i,
  input  logic                      core_sleep_i,
  input  logic                      switch_ack_ni,
  input  logic                      event_ready_i,
  output logic                      event_valid_o,
  output logic [wake_pkg::ID_W-1:0] event_id_o,
  output logic                      event_overrun_o,
  output logic                      powergate_switch_no,
  output logic                      powergate_iso_no,
  output logic                      subsystem_rst_no
);

  logic                ev_valid;
  logic                ev_ready;
  wake_pkg::event_t    ev_data;
  logic                q_valid;
  logic                q_ready;
  wake_pkg::event_t    q_data;
  wake_pkg::event_t    event_data;
  wake_pkg::pwr_ctrl_t pwr_ctrl;

  intr_collector #(
    .NUM_INTR(NUM_INTR)
  ) u_intr_collector (
    .clk_i,
    .rst_i,
    .intr_i,
    .ev_valid_o(ev_valid),
    .ev_ready_i(ev_ready),
    .ev_data_o (ev_data)
  );

  event_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_event_fifo (
    .clk_i,
    .rst_i,
    .wr_valid_i(ev_valid),
    .wr_ready_o(ev_ready),
    .wr_data_i (ev_data),
    .rd_valid_o(q_valid),
    .rd_ready_i(q_ready),
    .rd_data_o (q_data)
  );

  wake_controller u_wake_controller (
    .clk_i,
    .rst_i,
    .core_sleep_i,
    .switch_ack_ni,
    .q_valid_i    (q_valid),
    .q_ready_o    (q_ready),
    .q_data_i     (q_data),
    .event_valid_o,
    .event_ready_i,
    .event_data_o (event_data),
    .pwr_ctrl_o   (pwr_ctrl)
  );

  // unrolled for the pads and the switch cells
  assign event_id_o          = event_data.id;
  assign event_overrun_o     = event_data.overrun;
  assign powergate_switch_no = pwr_ctrl.pwrgate_en_n;
  assign powergate_iso_no    = pwr_ctrl.isogate_en_n;
  assign subsystem_rst_no    = pwr_ctrl.rst_n;

endmodule

/* hdl/wake_controller.sv */
`timescale 1ns/1ps
// wake controller for the cpu power domain
// gates the domain while the core sleeps, restores it when an event is queued

module wake_controller (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                core_sleep_i,
  input  logic                switch_ack_ni,
  input  logic                q_valid_i,
  output logic                q_ready_o,
  input  wake_pkg::event_t    q_data_i,
  output logic                event_valid_o,
  input  logic                event_ready_i,
  output wake_pkg::event_t    event_data_o,
  output wake_pkg::pwr_ctrl_t pwr_ctrl_o
);

  wake_pkg::pwr_state_e state_q;
  wake_pkg::pwr_state_e state_d;
  wake_pkg::pwr_ctrl_t  pwr_ctrl;
  logic                 dom_on;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      wake_pkg::PWR_ON: begin
        // only sleep with nothing left to deliver
        if (core_sleep_i && !q_valid_i) begin
          state_d = wake_pkg::PWR_ISO;
        end
      end
      wake_pkg::PWR_ISO: begin
        state_d = wake_pkg::PWR_OFF;
      end
      wake_pkg::PWR_OFF: begin
        if (q_valid_i) begin
          state_d = wake_pkg::PWR_SWITCH_ON;
        end
      end
      wake_pkg::PWR_SWITCH_ON: begin
        // wait for the switch cells to report power good
        if (!switch_ack_ni) begin
          state_d = wake_pkg::PWR_RELEASE;
        end
      end
      wake_pkg::PWR_RELEASE: begin
        state_d = wake_pkg::PWR_ON;
      end
      default: begin
        state_d = wake_pkg::PWR_ON;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= wake_pkg::PWR_ON;
    end else begin
      state_q <= state_d;
    end
  end

  // power controls per state
  // down: iso, then reset with switch off
  // up: switch on, iso release, then reset release
  always_comb begin
    case (state_q)
      wake_pkg::PWR_ON: begin
        pwr_ctrl.pwrgate_en_n = 1'b0;
        pwr_ctrl.isogate_en_n = 1'b1;
        pwr_ctrl.rst_n        = 1'b1;
      end
      wake_pkg::PWR_ISO: begin
        pwr_ctrl.pwrgate_en_n = 1'b0;
        pwr_ctrl.isogate_en_n = 1'b0;
        pwr_ctrl.rst_n        = 1'b1;
      end
      wake_pkg::PWR_OFF: begin
        pwr_ctrl.pwrgate_en_n = 1'b1;
        pwr_ctrl.isogate_en_n = 1'b0;
        pwr_ctrl.rst_n        = 1'b0;
      end
      wake_pkg::PWR_SWITCH_ON: begin
        pwr_ctrl.pwrgate_en_n = 1'b0;
        pwr_ctrl.isogate_en_n = 1'b0;
        pwr_ctrl.rst_n        = 1'b0;
      end
      wake_pkg::PWR_RELEASE: begin
        pwr_ctrl.pwrgate_en_n = 1'b0;
        pwr_ctrl.isogate_en_n = 1'b1;
        pwr_ctrl.rst_n        = 1'b0;
      end
      default: begin
        pwr_ctrl.pwrgate_en_n = 1'b0;
        pwr_ctrl.isogate_en_n = 1'b1;
        pwr_ctrl.rst_n        = 1'b1;
      end
    endcase
  end

  assign pwr_ctrl_o = pwr_ctrl;

  // events pass only with the domain fully up
  assign dom_on = (state_q == wake_pkg::PWR_ON);

  assign event_valid_o = dom_on & q_valid_i;
  assign q_ready_o     = dom_on & event_ready_i;
  assign event_data_o  = q_data_i;

endmodule

/* hdl/event_fifo.sv */
`timescale 1ns/1ps
// event queue between collector and wake controller
// circular buffer with valid/ready on both sides

module event_fifo #(
  parameter int FIFO_DEPTH = wake_pkg::DEF_FIFO_DEPTH
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             wr_valid_i,
  output logic             wr_ready_o,
  input  wake_pkg::event_t wr_data_i,
  output logic             rd_valid_o,
  input  logic             rd_ready_i,
  output wake_pkg::event_t rd_data_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  wake_pkg::event_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_wr;
  logic             do_rd;

  assign wr_ready_o = (count_q != (PTR_W + 1)'(FIFO_DEPTH));
  assign rd_valid_o = (count_q != '0);
  assign rd_data_o  = mem[rd_ptr_q];

  assign do_wr = wr_valid_i & wr_ready_o;
  assign do_rd = rd_valid_o & rd_ready_i;

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

endmodule

/* hdl/intr_collector.sv */
`timescale 1ns/1ps
// fast interrupt collector
// latches rising edges per line, tracks overruns, offers lowest pending line

module intr_collector #(
  parameter int NUM_INTR = wake_pkg::MAX_INTR
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [NUM_INTR-1:0] intr_i,
  output logic                ev_valid_o,
  input  logic                ev_ready_i,
  output wake_pkg::event_t    ev_data_o
);

  localparam int IW = wake_pkg::ID_W;

  logic [NUM_INTR-1:0] intr_q;
  logic [NUM_INTR-1:0] rise;
  logic [NUM_INTR-1:0] pending_q;
  logic [NUM_INTR-1:0] overrun_q;
  logic [NUM_INTR-1:0] taken;
  logic [IW-1:0]       low_id;
  logic [IW-1:0]       sel_id;
  logic [IW-1:0]       hold_id_q;
  logic                hold_q;
  logic                xfer;

  assign rise = intr_i & ~intr_q;

  // priority pick, lowest index wins
  always_comb begin
    low_id = '0;
    for (int i = NUM_INTR - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        low_id = IW'(i);
      end
    end
  end

  // a stalled offer keeps its line until the queue takes it
  assign sel_id = hold_q ? hold_id_q : low_id;

  assign ev_valid_o        = |pending_q;
  assign ev_data_o.id      = sel_id;
  assign ev_data_o.overrun = overrun_q[sel_id];

  assign xfer = ev_valid_o & ev_ready_i;

  always_comb begin
    for (int i = 0; i < NUM_INTR; i++) begin
      taken[i] = xfer && (sel_id == IW'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      intr_q    <= '0;
      pending_q <= '0;
      overrun_q <= '0;
      hold_q    <= 1'b0;
    end else begin
      intr_q    <= intr_i;
      // an edge in the cycle of its own transfer re-arms the line
      pending_q <= (pending_q & ~taken) | rise;
      // repeated edge on a pending line only marks an overrun
      overrun_q <= (overrun_q | (rise & pending_q)) & ~taken;
      hold_q    <= ev_valid_o & ~ev_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    hold_id_q <= sel_id;
  end

endmodule

/* hdl/wake_pkg.sv */
// wake unit shared definitions
// event payload, power-control bundle and power FSM states

package wake_pkg;

  // fast interrupt lines handled at most
  parameter int MAX_INTR = 16;

  // index width for one interrupt line
  parameter int ID_W = 4;

  // default event queue depth, power of two
  parameter int DEF_FIFO_DEPTH = 4;

  // one queued wake event
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic            overrun;
  } event_t;

  // cpu domain power controls, all active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
  } pwr_ctrl_t;

  // power sequencing states of the cpu domain
  typedef enum logic [2:0] {
    PWR_ON,
    PWR_ISO,
    PWR_OFF,
    PWR_SWITCH_ON,
    PWR_RELEASE
  } pwr_state_e;

endpackage
